//--- tests/asg_input.txt
# table: word count, then sample words (hex); each test: name size step offs (hex) bena binf
# bcyc bdly bnum retrig count (decimal), then count words {trg_out,vld,dat} (hex), one per cycle
16
0a00 0a01 0a02 0a03 0a04 0a05 0a06 0a07
0a08 0a09 0a0a 0a0b 0a0c 0a0d 0a0e 0a0f
cont_int 00090000 00030000 00020000 0 0 0 0 0 0 12
8000 4a02 4a05 4a08 4a01 4a04 4a07 4a00 4a03 4a06 4a09 4a02
restart 00090000 00030000 00020000 0 0 0 0 0 0 6
8000 4a02 4a05 4a08 4a01 4a04
frac_rep 00070000 0000c000 00018000 0 0 0 0 0 0 13
8000 4a01 4a02 4a03 4a03 4a04 4a05 4a06 4a06 4a07 4a00 4a01 4a01
frac_skip 00090000 00018000 00008000 0 0 0 0 0 0 11
8000 4a00 4a02 4a03 4a05 4a06 4a08 4a09 4a01 4a02 4a04
burst_gap 000f0000 00010000 00030000 1 0 2 1 2 2 14
8000 4a03 4a04 4a05 0000 8000 4a03 4a04 4a05 0000 0000 0000 0000 0000
burst_nogap 000f0000 00020000 00050000 1 0 1 0 3 0 9
8000 4a05 ca07 4a05 ca07 4a05 4a07 0000 0000

//--- verilog.f
verilog/asg_bus_pkg.sv
verilog/asg_cfg_pkg.sv
verilog/asg_table.sv
verilog/asg_sequencer.sv
verilog/asg_top.sv
tests/asg_properties.sv
tests/asg_tb.sv

//--- Bender.yml
package:
  name: asg

sources:
  # packages before the modules that use them
  - verilog/asg_bus_pkg.sv
  - verilog/asg_cfg_pkg.sv
  - verilog/asg_table.sv
  - verilog/asg_sequencer.sv
  - verilog/asg_top.sv
  - target: test
    files:
      - tests/asg_properties.sv
      - tests/asg_tb.sv

//--- tests/asg_tb.sv
/*
 * testbench for one waveform generator channel, driven from a data file
 * covers table access, continuous and burst play, reset and restart
 */

`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  localparam int unsigned addr_w = 8;
  // cycles on top of four per expected sample
  localparam int unsigned margin = 400;

  logic                  sto;
  logic                  ctl_rst;
  asg_bus_pkg::bus_req_t bus_req;
  asg_bus_pkg::bus_rsp_t bus_rsp;
  asg_cfg_pkg::cfg_t     cfg;
  logic                  trg_in;
  logic                  trg_out;
  asg_cfg_pkg::stream_t  str;

  // contents of the data file
  logic [15:0]       tbl_word [$];
  string             t_name   [$];
  asg_cfg_pkg::cfg_t t_cfg    [$];
  int                t_retrig [$];
  int                t_count  [$];
  int                t_first  [$];
  logic [15:0]       exp_word [$];

  int          fd;
  int          total;
  bit          loaded;
  string       cur_test;
  int unsigned seed;
  int unsigned first_rnd;

  asg_top #(.addr_w(addr_w)) uut (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .cfg     (cfg),
    .trg_in  (trg_in),
    .trg_out (trg_out),
    .str     (str)
  );

  // 100 ns clock
  initial begin
    sto = 1'b0;
    forever #50 sto = ~sto;
  end

  ////////////////////////////////////////
  // error handling
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_run($sformatf("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act));
    end
  endtask

  // bound sequencer checks
  initial begin
    wait (uut.u_sequencer.u_props.fail_cnt != 0);
    stop_run("a sequencer assertion failed");
  end

  ////////////////////////////////////////
  // data file
  ////////////////////////////////////////

  task automatic load_input();
    logic [8*160-1:0]  line;
    logic [31:0]       fx [3];
    int                n [7];
    string             name;
    logic [31:0]       w;
    asg_cfg_pkg::cfg_t c;
    int                r;
    int                cnt;
    int                i;
    bit                more;
    fd = $fopen("tests/asg_input.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the data file tests/asg_input.txt");
    end
    // two column description lines
    r = $fgets(line, fd);
    r = $fgets(line, fd);
    r = $fscanf(fd, "%d", cnt);
    if (r != 1) begin
      stop_run("data file has no table word count");
    end
    for (i = 0; i < cnt; i++) begin
      r = $fscanf(fd, "%h", w);
      if (r != 1) begin
        stop_run("data file ends inside the table words");
      end
      tbl_word.push_back(w[15:0]);
    end
    total = 0;
    more  = 1'b1;
    while (more) begin
      r = $fscanf(fd, "%s %h %h %h %d %d %d %d %d %d %d", name, fx[0], fx[1], fx[2],
                  n[0], n[1], n[2], n[3], n[4], n[5], n[6]);
      if (r == 11) begin
        c      = '0;
        c.size = fx[0];
        c.step = fx[1];
        c.offs = fx[2];
        c.bena = (n[0] != 0);
        c.binf = (n[1] != 0);
        c.bcyc = n[2][15:0];
        c.bdly = n[3];
        c.bnum = n[4][15:0];
        t_name.push_back(name);
        t_cfg.push_back(c);
        t_retrig.push_back(n[5]);
        t_count.push_back(n[6]);
        t_first.push_back(exp_word.size());
        for (i = 0; i < n[6]; i++) begin
          r = $fscanf(fd, "%h", w);
          if (r != 1) begin
            stop_run($sformatf("data file ends inside the expected words of %s", name));
          end
          exp_word.push_back(w[15:0]);
        end
        total += n[6];
      end else if (r <= 0) begin
        more = 1'b0;
      end else begin
        stop_run("data file holds a test record with missing fields");
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // host bus
  ////////////////////////////////////////

  // one strobe, ack expected on the following cycle only
  task automatic bus_access(input logic wr, input logic [15:0] addr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
    @(posedge sto);
    bus_req.wen   <= wr;
    bus_req.ren   <= ~wr;
    bus_req.addr  <= addr;
    bus_req.wdata <= wdata;
    @(negedge sto);
    check("ack before strobe taken", 1'b0, bus_rsp.ack);
    @(posedge sto);
    bus_req.wen <= 1'b0;
    bus_req.ren <= 1'b0;
    @(negedge sto);
    check("ack after strobe", 1'b1, bus_rsp.ack);
    rdata = bus_rsp.rdata;
    @(negedge sto);
    check("ack one cycle only", 1'b0, bus_rsp.ack);
  endtask

  task automatic table_test();
    logic [15:0] rd;
    int          i;
    cur_test = "table";
    for (i = 0; i < tbl_word.size(); i++) begin
      bus_access(1'b1, i[15:0], tbl_word[i], rd);
    end
    // table keeps 14 bits, upper read-back bits zero
    for (i = 0; i < tbl_word.size(); i++) begin
      bus_access(1'b0, i[15:0], 16'h0000, rd);
      check($sformatf("read-back %0d", i), {2'b00, tbl_word[i][13:0]}, rd);
    end
  endtask

  ////////////////////////////////////////
  // stream play
  ////////////////////////////////////////

  // one word per cycle: trg_out, vld, dat
  function automatic logic [15:0] stream_word();
    return {trg_out, str.vld, str.dat};
  endfunction

  // random idle wait, then a one-cycle trigger
  task automatic start_play(input asg_cfg_pkg::cfg_t c);
    int unsigned idle;
    idle = $urandom % 4;
    @(posedge sto);
    cfg <= c;
    repeat (idle) @(posedge sto);
    @(posedge sto);
    trg_in <= 1'b1;
    @(posedge sto);
    trg_in <= 1'b0;
  endtask

  task automatic play_test(input int idx);
    int k;
    int base;
    cur_test = t_name[idx];
    base     = t_first[idx];
    start_play(t_cfg[idx]);
    // first word lands in the cycle after the trigger is taken
    @(negedge sto);
    check("cycle 0", exp_word[base], stream_word());
    for (k = 1; k < t_count[idx]; k++) begin
      @(posedge sto);
      // retrigger while running, must be ignored
      trg_in <= (k == t_retrig[idx]);
      @(negedge sto);
      check($sformatf("cycle %0d", k), exp_word[base + k], stream_word());
    end
    @(posedge sto);
    trg_in <= 1'b0;
  endtask

  // stops any play, output must stay quiet afterwards
  task automatic reset_channel(input int cycles);
    @(posedge sto);
    ctl_rst <= 1'b1;
    @(negedge sto);
    repeat (cycles) begin
      @(negedge sto);
      check("vld in reset", 1'b0, str.vld);
      check("trg_out in reset", 1'b0, trg_out);
    end
    @(posedge sto);
    ctl_rst <= 1'b0;
    repeat (3) begin
      @(negedge sto);
      check("vld after reset", 1'b0, str.vld);
      check("trg_out after reset", 1'b0, trg_out);
    end
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    int i;
    ctl_rst   = 1'b1;
    bus_req   = '0;
    cfg       = '0;
    trg_in    = 1'b0;
    seed      = 32'h59a1_5f00;
    first_rnd = $urandom(seed);
    load_input();
    loaded = 1'b1;
    repeat (10) @(posedge sto);
    ctl_rst <= 1'b0;
    table_test();
    for (i = 0; i < t_name.size(); i++) begin
      play_test(i);
      reset_channel(4);
    end
    repeat (2) @(posedge sto);
    if (uut.u_sequencer.u_props.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d sequencer assertions failed", uut.u_sequencer.u_props.fail_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failures");
    end
  end

  initial begin
    wait (loaded);
    repeat (total * 4 + margin) @(posedge sto);
    $display("timeout: the tests did not finish within %0d cycles", total * 4 + margin);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- tests/asg_properties.sv
/*
 * sequencer assertions, bound into every asg_sequencer
 */

`timescale 1ns/1ps
`default_nettype none

module asg_properties #(
  parameter int unsigned addr_w = 8
) (
  input logic              sto,
  input logic              ctl_rst,
  input asg_cfg_pkg::cfg_t cfg,
  input logic              trg_out,
  input logic              rd_en,
  input logic [addr_w-1:0] rd_addr,
  input logic              per_end
);

  // assertion failure count
  int unsigned fail_cnt = 0;

  // back to back trg_out only when a burst period ran into the next one
  trg_pulse: assert property (@(posedge sto) disable iff (ctl_rst)
    trg_out |=> (!trg_out || $past(per_end)))
    else begin
      fail_cnt++;
      $error("trg_out high two cycles without a period start");
    end

  // no table read right out of reset
  rst_quiet: assert property (@(posedge sto) ctl_rst |=> !rd_en)
    else begin
      fail_cnt++;
      $error("rd_en high in the cycle after reset");
    end

  // pointer wrap keeps reads inside the table length
  addr_range: assert property (@(posedge sto) disable iff (ctl_rst)
    rd_en |-> (rd_addr <= cfg.size[asg_cfg_pkg::ptr_frac_w +: addr_w]))
    else begin
      fail_cnt++;
      $error("rd_addr beyond the table length");
    end

endmodule

bind asg_sequencer asg_properties #(.addr_w(addr_w)) u_props (
  .sto       (sto),
  .ctl_rst   (ctl_rst),
  .cfg       (cfg),
  .trg_out   (trg_out),
  .rd_en     (rd_en),
  .rd_addr   (rd_addr),
  .per_end   (per_end)
);

`default_nettype wire

//--- verilog/asg_top.sv
/*
 * one waveform generator channel, table plus sequencer
 */

`timescale 1ns/1ps
`default_nettype none

module asg_top #(
  // table index width, integer part of the pointer
  parameter int unsigned addr_w = 8
) (
  input  logic                  sto,
  input  logic                  ctl_rst,
  input  asg_bus_pkg::bus_req_t bus_req,
  output asg_bus_pkg::bus_rsp_t bus_rsp,
  input  asg_cfg_pkg::cfg_t     cfg,
  input  logic                  trg_in,
  output logic                  trg_out,
  output asg_cfg_pkg::stream_t  str
);

  // sequencer to table read port
  logic              rd_en;
  logic [addr_w-1:0] rd_addr;

  // pointer, FSM and trigger
  asg_sequencer #(.addr_w(addr_w)) u_sequencer (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .cfg     (cfg),
    .trg_in  (trg_in),
    .trg_out (trg_out),
    .rd_en   (rd_en),
    .rd_addr (rd_addr)
  );

  // RAM, host port and stream stage
  asg_table #(.addr_w(addr_w)) u_table (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .str     (str)
  );

endmodule

`default_nettype wire

//--- verilog/asg_sequencer.sv
/*
 * channel sequencer: idle/data/gap FSM with burst counters,
 * modulo fixed point table pointer and trigger output
 */

`timescale 1ns/1ps
`default_nettype none

module asg_sequencer #(
  parameter int unsigned addr_w = 8
) (
  input  logic               sto,
  input  logic               ctl_rst,
  input  asg_cfg_pkg::cfg_t  cfg,
  input  logic               trg_in,
  output logic               trg_out,
  output logic               rd_en,
  output logic [addr_w-1:0]  rd_addr
);

  typedef enum logic [1:0] {
    st_idle = 2'b00,
    st_data = 2'b01,
    st_gap  = 2'b10
  } state_t;

  // one table entry in pointer units, extended by the carry bit
  localparam logic [asg_cfg_pkg::ptr_w:0] ptr_one = 1 << asg_cfg_pkg::ptr_frac_w;

  state_t state;

  // burst counters
  logic [15:0] cnt_cyc;
  logic [31:0] cnt_dly;
  logic [15:0] cnt_rep;

  // period events
  logic per_end;
  logic per_last;
  logic per_start;

  // pointer and its next value, one carry bit above the container
  logic [asg_cfg_pkg::ptr_w-1:0] ptr_cur;
  logic [asg_cfg_pkg::ptr_w:0]   ptr_sum;
  logic [asg_cfg_pkg::ptr_w:0]   ptr_lim;
  logic [asg_cfg_pkg::ptr_w:0]   ptr_nxt;

  ////////////////////////////////////////
  // period events
  ////////////////////////////////////////

  // last cycle of a burst period, with or without gap
  assign per_end = cfg.bena &
                   (((state == st_data) & (cnt_cyc == '0) & (cnt_dly == '0)) |
                    ((state == st_gap) & (cnt_dly == '0)));

  // bnum of zero plays a single period
  assign per_last = ~cfg.binf & (cnt_rep <= 16'd1);

  // triggers only count while idle
  assign per_start = (trg_in & (state == st_idle)) | (per_end & ~per_last);

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= st_idle;
      cnt_cyc <= '0;
      cnt_dly <= '0;
      cnt_rep <= '0;
    end else if (per_start) begin
      state   <= st_data;
      cnt_cyc <= cfg.bcyc;
      cnt_dly <= cfg.bdly;
      // first period loads the repeat count
      if (state == st_idle) begin
        cnt_rep <= cfg.bnum;
      end else if (!cfg.binf) begin
        cnt_rep <= cnt_rep - 16'd1;
      end
    end else if (per_end) begin
      // all periods played
      state   <= st_idle;
      cnt_rep <= '0;
    end else if (cfg.bena) begin
      case (state)
        st_data: begin
          // data done with gap left, else count data
          if (cnt_cyc != '0) begin
            cnt_cyc <= cnt_cyc - 16'd1;
          end else begin
            state <= st_gap;
          end
        end
        st_gap: begin
          cnt_dly <= cnt_dly - 32'd1;
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // fixed point pointer
  ////////////////////////////////////////

  // table length in pointer units
  assign ptr_lim = {1'b0, cfg.size} + ptr_one;
  assign ptr_sum = {1'b0, ptr_cur} + {1'b0, cfg.step};
  // wrap modulo table length
  assign ptr_nxt = (ptr_sum >= ptr_lim) ? ptr_sum - ptr_lim : ptr_sum;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (per_start) begin
      ptr_cur <= cfg.offs;
    end else if (state == st_data) begin
      ptr_cur <= ptr_nxt[asg_cfg_pkg::ptr_w-1:0];
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // trigger notification, one cycle per period start
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_out <= 1'b0;
    end else begin
      trg_out <= per_start;
    end
  end

  // table read in every data cycle, integer part of pointer
  assign rd_en   = (state == st_data);
  assign rd_addr = ptr_cur[asg_cfg_pkg::ptr_frac_w +: addr_w];

endmodule

`default_nettype wire

//--- verilog/asg_table.sv
/*
 * waveform table RAM with host write and read-back port
 * and the registered stream read stage
 */

`timescale 1ns/1ps
`default_nettype none

module asg_table #(
  parameter int unsigned addr_w = 8
) (
  input  logic                  sto,
  input  logic                  ctl_rst,
  input  asg_bus_pkg::bus_req_t bus_req,
  output asg_bus_pkg::bus_rsp_t bus_rsp,
  input  logic                  rd_en,
  input  logic [addr_w-1:0]     rd_addr,
  output asg_cfg_pkg::stream_t  str
);

  // table depth and zero fill of read-back data
  localparam int unsigned depth = 2**addr_w;
  localparam int unsigned smp_w = $bits(asg_cfg_pkg::sample_t);
  localparam int unsigned pad_w = asg_bus_pkg::bus_data_w - smp_w;

  asg_cfg_pkg::sample_t mem [depth];

  logic [addr_w-1:0]                 bus_addr;
  logic                              ack_q;
  logic [asg_bus_pkg::bus_data_w-1:0] rdata_q;
  logic                              rd_ok;
  logic                              vld_q;
  asg_cfg_pkg::sample_t              dat_q;

  ////////////////////////////////////////
  // host port
  ////////////////////////////////////////

  // upper address bits ignored, table aliases
  assign bus_addr = bus_req.addr[addr_w-1:0];

  // write, low sample bits of the bus word
  always_ff @(posedge sto) begin
    if (bus_req.wen) begin
      mem[bus_addr] <= bus_req.wdata[smp_w-1:0];
    end
  end

  // read-back, valid with the ack
  always_ff @(posedge sto) begin
    if (bus_req.ren) begin
      rdata_q <= {{pad_w{1'b0}}, mem[bus_addr]};
    end
  end

  // ack one cycle after any strobe
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req.wen | bus_req.ren;
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.rdata = rdata_q;

  ////////////////////////////////////////
  // stream read stage
  ////////////////////////////////////////

  // a read in the reset cycle must not leak out as data
  assign rd_ok = rd_en & ~ctl_rst;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_en;
    end
  end

  // zero data outside data cycles
  always_ff @(posedge sto) begin
    dat_q <= rd_ok ? mem[rd_addr] : '0;
  end

  assign str.vld = vld_q;
  assign str.dat = dat_q;

endmodule

`default_nettype wire

//--- verilog/asg_cfg_pkg.sv
/*
 * channel data types: fixed point pointer format, DAC sample,
 * stream output word and channel configuration
 */

`default_nettype none

package asg_cfg_pkg;

  ////////////////////////////////////////
  // fixed point pointer
  ////////////////////////////////////////

  // fraction bits below the table index
  localparam int unsigned ptr_frac_w = 16;
  // container for pointer, size, step, offset
  // integer part is addr_w bits of it, up to 16
  localparam int unsigned ptr_w = 32;

  ////////////////////////////////////////
  // samples and stream
  ////////////////////////////////////////

  // one DAC code
  typedef logic [13:0] sample_t;

  // no ready, the stream never stalls
  typedef struct packed {
    logic    vld;
    sample_t dat;
  } stream_t;

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  typedef struct packed {
    logic [ptr_w-1:0] size;  // table length minus one
    logic [ptr_w-1:0] step;  // pointer increment per data cycle
    logic [ptr_w-1:0] offs;  // start pointer, sets phase
    logic             bena;  // burst mode on
    logic             binf;  // repeat bursts without end
    logic [15:0]      bcyc;  // data cycles minus one
    logic [31:0]      bdly;  // gap cycles, zero means no gap
    logic [15:0]      bnum;  // number of periods
  } cfg_t;

endpackage

`default_nettype wire

//--- verilog/asg_bus_pkg.sv
/*
 * host register bus of the waveform generator channel
 * strobe and ack request and response words
 */

`default_nettype none

package asg_bus_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // byte-free word addressing
  localparam int unsigned bus_addr_w = 16;
  localparam int unsigned bus_data_w = 16;

  ////////////////////////////////////////
  // request and response
  ////////////////////////////////////////

  // one-cycle strobes, at most one of them per cycle
  typedef struct packed {
    logic                  wen;
    logic                  ren;
    logic [bus_addr_w-1:0] addr;
    logic [bus_data_w-1:0] wdata;
  } bus_req_t;

  // ack one cycle after either strobe
  // rdata only meaningful with the ack of a read
  typedef struct packed {
    logic                  ack;
    logic [bus_data_w-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire
